//--- logic/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    localparam int DATA_WIDTH   = 56;
    localparam int PARITY_WIDTH = 7;
    localparam int DEPTH        = 64;
    localparam int ADDR_WIDTH   = 6;
    localparam int CNT_WIDTH    = 16;

    // one stored word with the check bits in the upper bits
    typedef struct packed {
        logic [PARITY_WIDTH-1:0] parity;
        logic [DATA_WIDTH-1:0]   data;
    } codeword_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        codeword_t             inj_mask;
    } wr_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic                  sbit_err;
        logic                  dbit_err;
    } rd_rsp_t;

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_SINGLE,
        ERR_DOUBLE
    } err_kind_t;

    // entry i is the syndrome produced by a flip of data bit i
    // every entry has odd weight, so any two flipped bits give an even nonzero syndrome
    localparam logic [PARITY_WIDTH-1:0] SYNDROME_TABLE [DATA_WIDTH] = '{
        7'b1000011,
        7'b1000101,
        7'b1000110,
        7'b0000111,
        7'b1001001,
        7'b1001010,
        7'b0001011,
        7'b1001100,
        7'b0001101,
        7'b0001110,
        7'b1001111,
        7'b1010001,
        7'b1010010,
        7'b0010011,
        7'b1010100,
        7'b0010101,
        7'b0010110,
        7'b1010111,
        7'b1011000,
        7'b0011001,
        7'b0011010,
        7'b1011011,
        7'b0011100,
        7'b1011101,
        7'b1011110,
        7'b0011111,
        7'b1100001,
        7'b1100010,
        7'b0100011,
        7'b1100100,
        7'b0100101,
        7'b0100110,
        7'b1100111,
        7'b1101000,
        7'b0101001,
        7'b0101010,
        7'b1101011,
        7'b0101100,
        7'b1101101,
        7'b1101110,
        7'b0101111,
        7'b1110000,
        7'b0110001,
        7'b0110010,
        7'b1110011,
        7'b0110100,
        7'b1110101,
        7'b1110110,
        7'b0110111,
        7'b0111000,
        7'b1111001,
        7'b1111010,
        7'b0111011,
        7'b1111100,
        7'b0111101,
        7'b0111110
    };

    // check bit j is the XOR of every data bit whose syndrome has bit j set
    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            p = p ^ (SYNDROME_TABLE[i] & {PARITY_WIDTH{d[i]}});
        end
        return p;
    endfunction

endpackage

`default_nettype wire

//--- logic/ecc_56_cal.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_56_cal (
    input  wire logic [ecc_pkg::DATA_WIDTH-1:0]   data_in,
    input  wire logic [ecc_pkg::PARITY_WIDTH-1:0] parity_in,
    input  wire logic                             bypass,
    output logic      [ecc_pkg::DATA_WIDTH-1:0]   data_out,
    output logic      [ecc_pkg::PARITY_WIDTH-1:0] parity_out,
    output logic                                  sbit_err,
    output logic                                  dbit_err
);
    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   corr_mask;
    logic                    table_hit;
    err_kind_t               err_kind;

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // at most one table entry can match, since all syndromes are distinct
    always_comb begin
        corr_mask = '0;
        table_hit = 1'b0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (syndrome == SYNDROME_TABLE[i]) begin
                corr_mask[i] = 1'b1;
                table_hit    = 1'b1;
            end
        end
    end

    // a syndrome with a single bit set points at a failed check bit
    always_comb begin
        if (syndrome == '0) begin
            err_kind = ERR_NONE;
        end else if (table_hit || $onehot(syndrome)) begin
            err_kind = ERR_SINGLE;
        end else begin
            err_kind = ERR_DOUBLE;
        end
    end

    always_comb begin
        if (bypass || err_kind != ERR_SINGLE) begin
            data_out = data_in;
        end else begin
            data_out = data_in ^ corr_mask;
        end
    end

    assign sbit_err = !bypass && (err_kind == ERR_SINGLE);
    assign dbit_err = !bypass && (err_kind == ERR_DOUBLE);

    always_comb begin
        assert ($countones(corr_mask) <= 1)
            else $error("ecc_56_cal: more than one data bit marked for correction");
    end

endmodule

`default_nettype wire

//--- logic/ecc_mem_array.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_array (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            wr_en,
    input  wire ecc_pkg::wr_req_t                wr_req,
    input  wire logic                            rd_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0]  rd_addr,
    output logic                                 raw_valid,
    output ecc_pkg::codeword_t                   raw_word,
    output logic      [ecc_pkg::ADDR_WIDTH-1:0]  raw_addr
);
    import ecc_pkg::*;

    codeword_t mem [DEPTH];
    codeword_t wr_word;

    // the injection mask lets software corrupt data or check bits on purpose
    always_comb begin
        wr_word.data   = wr_req.data;
        wr_word.parity = ecc_encode(wr_req.data);
        wr_word        = wr_word ^ wr_req.inj_mask;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_req.addr] <= wr_word;
        end
    end

    // read sees the old word on a same-address write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            raw_word <= mem[rd_addr];
            raw_addr <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= rd_en;
        end
    end

    wr_addr_known : assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_req.addr))
        else $error("ecc_mem_array: write address unknown");

    rd_addr_known : assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !$isunknown(rd_addr))
        else $error("ecc_mem_array: read address unknown");

endmodule

`default_nettype wire

//--- logic/ecc_read_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_read_stage (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            bypass,
    input  wire logic                            raw_valid,
    input  wire ecc_pkg::codeword_t              raw_word,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0]  raw_addr,
    output logic                                 rd_valid,
    output ecc_pkg::rd_rsp_t                     rd_rsp
);
    import ecc_pkg::*;

    logic [DATA_WIDTH-1:0] data_fix;
    logic                  sbit;
    logic                  dbit;

    ecc_56_cal u_cal (
        .data_in    (raw_word.data),
        .parity_in  (raw_word.parity),
        .bypass     (bypass),
        .data_out   (data_fix),
        .parity_out (),
        .sbit_err   (sbit),
        .dbit_err   (dbit)
    );

    always_ff @(posedge clk) begin
        if (raw_valid) begin
            rd_rsp.addr     <= raw_addr;
            rd_rsp.data     <= data_fix;
            rd_rsp.sbit_err <= sbit;
            rd_rsp.dbit_err <= dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= raw_valid;
        end
    end

    // flags are sampled one cycle after bypass was applied to the decoder
    no_flags_in_bypass : assert property (@(posedge clk) disable iff (reset)
        rd_valid && $past(bypass) |-> !rd_rsp.sbit_err && !rd_rsp.dbit_err)
        else $error("ecc_read_stage: error flag raised while bypassed");

endmodule

`default_nettype wire

//--- logic/ecc_err_log.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_err_log (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            clear,
    input  wire logic                            rd_valid,
    input  wire ecc_pkg::rd_rsp_t                rd_rsp,
    output logic      [ecc_pkg::CNT_WIDTH-1:0]   sbit_cnt,
    output logic      [ecc_pkg::CNT_WIDTH-1:0]   dbit_cnt,
    output logic      [ecc_pkg::ADDR_WIDTH-1:0]  last_dbit_addr
);
    import ecc_pkg::*;

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = rd_valid && rd_rsp.sbit_err;
    assign dbit_hit = rd_valid && rd_rsp.dbit_err;

    // counters stick at all ones instead of wrapping
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sbit_cnt <= '0;
        end else if (sbit_hit && sbit_cnt != {CNT_WIDTH{1'b1}}) begin
            sbit_cnt <= sbit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            dbit_cnt <= '0;
        end else if (dbit_hit && dbit_cnt != {CNT_WIDTH{1'b1}}) begin
            dbit_cnt <= dbit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            last_dbit_addr <= '0;
        end else if (dbit_hit) begin
            last_dbit_addr <= rd_rsp.addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/ecc_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_ram_top (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            wr_en,
    input  wire ecc_pkg::wr_req_t                wr_req,
    input  wire logic                            rd_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0]  rd_addr,
    input  wire logic                            bypass,
    input  wire logic                            clear,
    output logic                                 rd_valid,
    output ecc_pkg::rd_rsp_t                     rd_rsp,
    output logic      [ecc_pkg::CNT_WIDTH-1:0]   sbit_cnt,
    output logic      [ecc_pkg::CNT_WIDTH-1:0]   dbit_cnt,
    output logic      [ecc_pkg::ADDR_WIDTH-1:0]  last_dbit_addr
);
    import ecc_pkg::*;

    logic                  raw_valid;
    codeword_t             raw_word;
    logic [ADDR_WIDTH-1:0] raw_addr;

    ecc_mem_array u_array (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_req    (wr_req),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .raw_valid (raw_valid),
        .raw_word  (raw_word),
        .raw_addr  (raw_addr)
    );

    // decode and register in the second cycle of the read
    ecc_read_stage u_read (
        .clk       (clk),
        .reset     (reset),
        .bypass    (bypass),
        .raw_valid (raw_valid),
        .raw_word  (raw_word),
        .raw_addr  (raw_addr),
        .rd_valid  (rd_valid),
        .rd_rsp    (rd_rsp)
    );

    ecc_err_log u_log (
        .clk            (clk),
        .reset          (reset),
        .clear          (clear),
        .rd_valid       (rd_valid),
        .rd_rsp         (rd_rsp),
        .sbit_cnt       (sbit_cnt),
        .dbit_cnt       (dbit_cnt),
        .last_dbit_addr (last_dbit_addr)
    );

endmodule

`default_nettype wire

//--- tb/tb_ecc_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_ram;
    import ecc_pkg::*;

    localparam int NUM_ROWS = 14;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        codeword_t             mask;
        logic                  bypass;
        logic [DATA_WIDTH-1:0] exp_data;
        logic                  exp_sbit;
        logic                  exp_dbit;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  wr_en;
    wr_req_t               wr_req;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  bypass;
    logic                  clear;
    logic                  rd_valid;
    rd_rsp_t               rd_rsp;
    logic [CNT_WIDTH-1:0]  sbit_cnt;
    logic [CNT_WIDTH-1:0]  dbit_cnt;
    logic [ADDR_WIDTH-1:0] last_dbit_addr;

    row_t rows [NUM_ROWS];
    row_t exp_q [$];
    int   issue_q [$];
    row_t exp_row;
    int   issued;
    int   cycle = 0;
    int   value_errors = 0;
    int   other_errors = 0;

    ecc_ram_top UUT (
        .clk            (clk),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_req         (wr_req),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .bypass         (bypass),
        .clear          (clear),
        .rd_valid       (rd_valid),
        .rd_rsp         (rd_rsp),
        .sbit_cnt       (sbit_cnt),
        .dbit_cnt       (dbit_cnt),
        .last_dbit_addr (last_dbit_addr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic codeword_t data_flip(input int b);
        codeword_t m;
        m = '0;
        m.data[b] = 1'b1;
        return m;
    endfunction

    function automatic codeword_t check_flip(input int j);
        codeword_t m;
        m = '0;
        m.parity[j] = 1'b1;
        return m;
    endfunction

    // one flipped bit is corrected, two are reported and left as stored
    task automatic set_row(input int idx, input logic [ADDR_WIDTH-1:0] addr,
                           input codeword_t mask, input logic byp);
        logic [63:0] r;
        int          n;
        r = {$urandom(), $urandom()};
        n = $countones(mask);
        rows[idx].addr     = addr;
        rows[idx].data     = r[DATA_WIDTH-1:0];
        rows[idx].mask     = mask;
        rows[idx].bypass   = byp;
        rows[idx].exp_data = rows[idx].data;
        rows[idx].exp_sbit = 1'b0;
        rows[idx].exp_dbit = 1'b0;
        if (byp || n == 2) begin
            rows[idx].exp_data = rows[idx].data ^ mask.data;
        end
        if (!byp && n == 1) begin
            rows[idx].exp_sbit = 1'b1;
        end
        if (!byp && n == 2) begin
            rows[idx].exp_dbit = 1'b1;
        end
    endtask

    task automatic compare_field(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
        assert (got_val === exp_val)
            else begin
                value_errors++;
                $display("** Error @ %0t ns: %s expected %h, actual %h",
                         $time, name, exp_val, got_val);
            end
    endtask

    // responses are taken at the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        if (!reset) begin
            if (rd_en) begin
                issue_q.push_back(cycle);
            end
            if (rd_valid) begin
                assert (exp_q.size() != 0 && issue_q.size() != 0)
                    else begin
                        other_errors++;
                        $display("rd_valid came at %0t ns with no read outstanding", $time);
                    end
                if (exp_q.size() != 0 && issue_q.size() != 0) begin
                    exp_row = exp_q.pop_front();
                    issued  = issue_q.pop_front();
                    compare_field("rd_valid latency", 64'(2), 64'(cycle - issued));
                    compare_field("rd_rsp.addr", 64'(exp_row.addr), 64'(rd_rsp.addr));
                    compare_field("rd_rsp.data", 64'(exp_row.exp_data), 64'(rd_rsp.data));
                    compare_field("rd_rsp.sbit_err", 64'(exp_row.exp_sbit),
                                  64'(rd_rsp.sbit_err));
                    compare_field("rd_rsp.dbit_err", 64'(exp_row.exp_dbit),
                                  64'(rd_rsp.dbit_err));
                end
            end
        end
    end

    initial begin
        repeat (NUM_ROWS * 2 + 50) @(posedge clk);
        $display("watchdog: run timed out before all reads completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int                    exp_sbit_total;
        int                    exp_dbit_total;
        logic [ADDR_WIDTH-1:0] exp_last_addr;
        clk     = 1'b0;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_req  = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        bypass  = 1'b0;
        clear   = 1'b0;
        void'($urandom(32'h783f8bd6));

        set_row(0, 6'd0, '0, 1'b0);
        set_row(1, 6'd1, '0, 1'b0);
        set_row(2, 6'd5, data_flip(0), 1'b0);
        set_row(3, 6'd9, data_flip(17), 1'b0);
        set_row(4, 6'd12, data_flip(33), 1'b0);
        set_row(5, 6'd20, data_flip(55), 1'b0);
        set_row(6, 6'd21, check_flip(0), 1'b0);
        set_row(7, 6'd30, check_flip(6), 1'b0);
        set_row(8, 6'd33, data_flip(3) | data_flip(40), 1'b0);
        set_row(9, 6'd40, data_flip(10) | check_flip(2), 1'b0);
        set_row(10, 6'd47, data_flip(22), 1'b1);
        set_row(11, 6'd50, '0, 1'b1);
        set_row(12, 6'd63, data_flip(1) | data_flip(2), 1'b0);
        set_row(13, 6'd58, data_flip(44), 1'b0);

        exp_sbit_total = 0;
        exp_dbit_total = 0;
        exp_last_addr  = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            exp_sbit_total += int'(rows[i].exp_sbit);
            exp_dbit_total += int'(rows[i].exp_dbit);
            if (rows[i].exp_dbit) begin
                exp_last_addr = rows[i].addr;
            end
        end

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        compare_field("rd_valid", 64'(0), 64'(rd_valid));
        compare_field("sbit_cnt", 64'(0), 64'(sbit_cnt));
        compare_field("dbit_cnt", 64'(0), 64'(dbit_cnt));
        compare_field("last_dbit_addr", 64'(0), 64'(last_dbit_addr));

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #1;
            wr_en           = 1'b1;
            wr_req.addr     = rows[i].addr;
            wr_req.data     = rows[i].data;
            wr_req.inj_mask = rows[i].mask;
        end
        @(posedge clk);
        #1 wr_en = 1'b0;

        // bypass must follow its read by one cycle, when the word reaches the decoder
        for (int k = 0; k <= NUM_ROWS; k++) begin
            @(posedge clk);
            #1;
            bypass = (k > 0) ? rows[k-1].bypass : 1'b0;
            if (k < NUM_ROWS) begin
                rd_en   = 1'b1;
                rd_addr = rows[k].addr;
                exp_q.push_back(rows[k]);
            end else begin
                rd_en = 1'b0;
            end
        end
        @(posedge clk);
        #1 bypass = 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        compare_field("sbit_cnt", 64'(exp_sbit_total), 64'(sbit_cnt));
        compare_field("dbit_cnt", 64'(exp_dbit_total), 64'(dbit_cnt));
        compare_field("last_dbit_addr", 64'(exp_last_addr), 64'(last_dbit_addr));

        clear = 1'b1;
        @(posedge clk);
        #1 clear = 1'b0;
        compare_field("sbit_cnt", 64'(0), 64'(sbit_cnt));
        compare_field("dbit_cnt", 64'(0), 64'(dbit_cnt));
        compare_field("last_dbit_addr", 64'(0), 64'(last_dbit_addr));

        $display("errors: %0d value mismatches, %0d protocol failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/ecc_pkg.sv
logic/ecc_56_cal.sv
logic/ecc_mem_array.sv
logic/ecc_read_stage.sv
logic/ecc_err_log.sv
logic/ecc_ram_top.sv
tb/tb_ecc_ram.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ecc_ram
FILELIST = list.f

SOURCES  = $(wildcard logic/*.sv tb/*.sv)
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
